/* list.f */
source/sonata_pkg.sv
source/reg_write_bank.sv
source/reg_read_mux.sv
source/crypt_ctrl.sv
source/sonata_reg_top.sv
tests/sonata_reg_properties.sv
tests/tb_sonata_reg.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the register front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_sonata_reg \
   -o sim_tb_sonata_reg \
   && ./obj_dir/sim_tb_sonata_reg | tee /dev/stderr | grep -q "Test completed successfully" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

/* source/crypt_ctrl.sv */
`default_nettype none

module crypt_ctrl import sonata_pkg::*; (
   input  wire                 usb_clk,
   input  wire                 reset_i,
   input  wire crypt_regs_t    regs_i,
   input  wire crypt_rsp_t     crypt_rsp_i,
   output crypt_cmd_t          crypt_cmd_o,
   output logic [BLOCK_W-1:0]  textout_o,
   output logic [BLOCK_W-1:0]  cipherout_o,
   output logic                busy_o
);

   logic       always_go;   // restart toggle for always-on mode
   logic       done_r;
   logic       done_pulse;
   logic [1:0] busy_pipe;

   ////////////////////////////////////////////////////////////////////////////
   // start sequencing
   ////////////////////////////////////////////////////////////////////////////
   // manual mode passes the go pulse, always-on mode restarts the core
   // every time it goes idle. the toggle is held low outside always-on mode
   // so the first restart cannot land next to a manual go
   always_ff @(posedge usb_clk) begin
      if (reset_i || !regs_i.always_on || always_go) begin
         always_go <= 1'b0;
      end else if (!crypt_rsp_i.busy) begin
         always_go <= 1'b1;
      end
   end

   assign crypt_cmd_o = '{
      key:      regs_i.key,
      textin:   regs_i.textin,
      cipherin: regs_i.cipherin,
      start:    regs_i.always_on ? always_go : regs_i.go_pulse
   };

   ////////////////////////////////////////////////////////////////////////////
   // result capture and busy
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         done_r    <= 1'b0;
         busy_pipe <= 2'b00;
      end else begin
         done_r    <= crypt_rsp_i.done & DONE_EDGE_SENSITIVE;
         busy_pipe <= {busy_pipe[0], crypt_rsp_i.busy};  // core is an outside source
      end
   end

   assign done_pulse = crypt_rsp_i.done & ~done_r;

   always_ff @(posedge usb_clk) begin
      if (done_pulse) begin
         textout_o   <= crypt_rsp_i.textout;
         cipherout_o <= crypt_rsp_i.cipherout;
      end
   end

   assign busy_o = busy_pipe[1];

endmodule

`default_nettype wire

/* source/reg_read_mux.sv */
`default_nettype none

module reg_read_mux import sonata_pkg::*; (
   input  wire                   usb_clk,
   input  wire reg_bus_t         reg_bus_i,
   input  wire crypt_regs_t      regs_i,
   input  wire [BLOCK_W-1:0]     textout_i,
   input  wire [BLOCK_W-1:0]     cipherout_i,
   input  wire                   busy_i,            // already synchronized
   input  wire                   mmcm_locked_i,
   input  wire                   mmcm_hr_locked_i,
   input  wire [DIPS_W-1:0]      dips_i,
   input  wire [ANALOG_W-1:0]    analog_digital_i,
   output logic [DATA_W-1:0]     read_data_o
);

   logic [DATA_W-1:0]     rd_data;
   logic [BYTE_SEL_W-1:0] byte_sel;
   logic [6:0]            bit_base;   // first bit of the selected block byte

   assign byte_sel = reg_bus_i.bytecnt[BYTE_SEL_W-1:0];
   assign bit_base = {byte_sel, 3'b000};

   ////////////////////////////////////////////////////////////////////////////
   // read decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;   // zero unless a read is active
      if (reg_bus_i.addrvalid && reg_bus_i.read) begin
         case (reg_bus_i.address)
            REG_CLKSETTINGS:     rd_data = {6'b0, mmcm_hr_locked_i, mmcm_locked_i};
            REG_USER_LED:        rd_data = DATA_W'(regs_i.user_led);
            REG_CRYPT_TYPE:      rd_data = CRYPT_TYPE;
            REG_CRYPT_REV:       rd_data = CRYPT_REV;
            REG_IDENTIFY:        rd_data = IDENTIFY;
            REG_CRYPT_GO:        rd_data = DATA_W'(busy_i);
            REG_AES_ALWAYS_ON:   rd_data = DATA_W'(regs_i.always_on);
            REG_CRYPT_KEY:       rd_data = regs_i.key[bit_base +: DATA_W];
            REG_CRYPT_TEXTIN:    rd_data = regs_i.textin[bit_base +: DATA_W];
            REG_CRYPT_CIPHERIN:  rd_data = regs_i.cipherin[bit_base +: DATA_W];
            REG_CRYPT_TEXTOUT:   rd_data = textout_i[bit_base +: DATA_W];
            REG_CRYPT_CIPHEROUT: rd_data = cipherout_i[bit_base +: DATA_W];
            // two bytes of switches, low byte first
            REG_DIPS:            rd_data = dips_i[{reg_bus_i.bytecnt[0], 3'b000} +: DATA_W];
            REG_ANALOG_DIGITAL:  rd_data = DATA_W'(analog_digital_i);
            default:             rd_data = '0;
         endcase
      end
   end

   // output stage, data follows the read strobe by one cycle
   always_ff @(posedge usb_clk) begin
      read_data_o <= rd_data;
   end

endmodule

`default_nettype wire

/* source/reg_write_bank.sv */
`default_nettype none

module reg_write_bank import sonata_pkg::*; (
   input  wire              usb_clk,
   input  wire              reset_i,
   input  wire reg_bus_t    reg_bus_i,
   output crypt_regs_t      regs_o
);

   logic [BLOCK_W-1:0]    key_q;
   logic [BLOCK_W-1:0]    textin_q;
   logic [BLOCK_W-1:0]    cipherin_q;
   logic                  user_led_q;
   logic                  always_on_q;
   logic                  go_pulse_q;
   logic                  wr_en;
   logic [BYTE_SEL_W-1:0] byte_sel;
   logic [ADDR_W-1:0]     wr_addr;
   logic [DATA_W-1:0]     wr_data;

   assign wr_en    = reg_bus_i.addrvalid & reg_bus_i.write;
   assign byte_sel = reg_bus_i.bytecnt[BYTE_SEL_W-1:0];  // blocks are 16 bytes
   assign wr_addr  = reg_bus_i.address;
   assign wr_data  = reg_bus_i.write_data;

   ////////////////////////////////////////////////////////////////////////////
   // control bits
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         user_led_q  <= 1'b0;
         always_on_q <= 1'b0;
         go_pulse_q  <= 1'b0;
      end else begin
         // writing the go register only makes a pulse, no state is kept
         go_pulse_q <= wr_en && (wr_addr == REG_CRYPT_GO);

         if (wr_en && (wr_addr == REG_USER_LED)) begin
            user_led_q <= wr_data[0];
         end
         if (wr_en && (wr_addr == REG_AES_ALWAYS_ON)) begin
            always_on_q <= wr_data[0];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // key and text blocks, filled a byte at a time
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge usb_clk) begin
      if (wr_en) begin
         case (wr_addr)
            REG_CRYPT_KEY: begin
               key_q[{byte_sel, 3'b000} +: DATA_W] <= wr_data;
            end
            REG_CRYPT_TEXTIN: begin
               textin_q[{byte_sel, 3'b000} +: DATA_W] <= wr_data;
            end
            REG_CRYPT_CIPHERIN: begin
               cipherin_q[{byte_sel, 3'b000} +: DATA_W] <= wr_data;
            end
            default: begin
            end
         endcase
      end
   end

   assign regs_o = '{
      key:       key_q,
      textin:    textin_q,
      cipherin:  cipherin_q,
      user_led:  user_led_q,
      always_on: always_on_q,
      go_pulse:  go_pulse_q
   };

endmodule

`default_nettype wire

/* source/sonata_pkg.sv */
`default_nettype none

package sonata_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int ADDR_W     = 8;
   localparam int DATA_W     = 8;
   localparam int BYTECNT_W  = 7;
   localparam int BLOCK_W    = 128;                       // key and text blocks
   localparam int BYTE_SEL_W = $clog2(BLOCK_W / DATA_W);  // byte index into a block
   localparam int DIPS_W     = 16;
   localparam int ANALOG_W   = 6;

   // 1: capture results on the first done cycle only
   localparam bit DONE_EDGE_SENSITIVE = 1'b1;

   // identification bytes
   localparam logic [DATA_W-1:0] CRYPT_TYPE = 8'd2;
   localparam logic [DATA_W-1:0] CRYPT_REV  = 8'd4;
   localparam logic [DATA_W-1:0] IDENTIFY   = 8'h2e;

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [ADDR_W-1:0] REG_CLKSETTINGS     = 8'h00;
   localparam logic [ADDR_W-1:0] REG_USER_LED        = 8'h01;
   localparam logic [ADDR_W-1:0] REG_CRYPT_TYPE      = 8'h02;
   localparam logic [ADDR_W-1:0] REG_CRYPT_REV       = 8'h03;
   localparam logic [ADDR_W-1:0] REG_IDENTIFY        = 8'h04;
   localparam logic [ADDR_W-1:0] REG_CRYPT_GO        = 8'h05;  // write starts, read is busy
   localparam logic [ADDR_W-1:0] REG_CRYPT_TEXTIN    = 8'h06;
   localparam logic [ADDR_W-1:0] REG_CRYPT_CIPHERIN  = 8'h07;
   localparam logic [ADDR_W-1:0] REG_CRYPT_TEXTOUT   = 8'h08;
   localparam logic [ADDR_W-1:0] REG_CRYPT_CIPHEROUT = 8'h09;
   localparam logic [ADDR_W-1:0] REG_CRYPT_KEY       = 8'h0a;
   localparam logic [ADDR_W-1:0] REG_AES_ALWAYS_ON   = 8'h0c;
   localparam logic [ADDR_W-1:0] REG_DIPS            = 8'h20;
   localparam logic [ADDR_W-1:0] REG_ANALOG_DIGITAL  = 8'h21;

   // host register bus, one byte per access
   typedef struct packed {
      logic [ADDR_W-1:0]    address;
      logic [BYTECNT_W-1:0] bytecnt;
      logic [DATA_W-1:0]    write_data;
      logic                 read;
      logic                 write;
      logic                 addrvalid;
   } reg_bus_t;

   // towards the crypto core
   typedef struct packed {
      logic [BLOCK_W-1:0] key;
      logic [BLOCK_W-1:0] textin;
      logic [BLOCK_W-1:0] cipherin;
      logic               start;
   } crypt_cmd_t;

   // back from the crypto core
   typedef struct packed {
      logic [BLOCK_W-1:0] textout;
      logic [BLOCK_W-1:0] cipherout;
      logic               done;
      logic               busy;
   } crypt_rsp_t;

   // writable register state
   typedef struct packed {
      logic [BLOCK_W-1:0] key;
      logic [BLOCK_W-1:0] textin;
      logic [BLOCK_W-1:0] cipherin;
      logic               user_led;
      logic               always_on;
      logic               go_pulse;
   } crypt_regs_t;

endpackage

`default_nettype wire

/* source/sonata_reg_top.sv */
`default_nettype none

module sonata_reg_top import sonata_pkg::*; (
   input  wire                   usb_clk,
   input  wire                   reset_i,
   input  wire reg_bus_t         reg_bus_i,
   input  wire crypt_rsp_t       crypt_rsp_i,
   input  wire                   mmcm_locked_i,
   input  wire                   mmcm_hr_locked_i,
   input  wire [DIPS_W-1:0]      dips_i,
   input  wire [ANALOG_W-1:0]    analog_digital_i,
   output wire [DATA_W-1:0]      read_data_o,
   output wire crypt_cmd_t       crypt_cmd_o,
   output wire                   user_led_o
);

   crypt_regs_t        regs;
   logic [BLOCK_W-1:0] textout;     // captured results
   logic [BLOCK_W-1:0] cipherout;
   logic               busy_sync;

   ////////////////////////////////////////////////////////////////////////////
   // host writes
   ////////////////////////////////////////////////////////////////////////////
   reg_write_bank u_write_bank (
      .usb_clk   (usb_clk),
      .reset_i   (reset_i),
      .reg_bus_i (reg_bus_i),
      .regs_o    (regs)
   );

   ////////////////////////////////////////////////////////////////////////////
   // core control
   ////////////////////////////////////////////////////////////////////////////
   crypt_ctrl u_crypt_ctrl (
      .usb_clk     (usb_clk),
      .reset_i     (reset_i),
      .regs_i      (regs),
      .crypt_rsp_i (crypt_rsp_i),
      .crypt_cmd_o (crypt_cmd_o),
      .textout_o   (textout),
      .cipherout_o (cipherout),
      .busy_o      (busy_sync)
   );

   ////////////////////////////////////////////////////////////////////////////
   // host reads
   ////////////////////////////////////////////////////////////////////////////
   reg_read_mux u_read_mux (
      .usb_clk          (usb_clk),
      .reg_bus_i        (reg_bus_i),
      .regs_i           (regs),
      .textout_i        (textout),
      .cipherout_i      (cipherout),
      .busy_i           (busy_sync),
      .mmcm_locked_i    (mmcm_locked_i),
      .mmcm_hr_locked_i (mmcm_hr_locked_i),
      .dips_i           (dips_i),
      .analog_digital_i (analog_digital_i),
      .read_data_o      (read_data_o)
   );

   assign user_led_o = regs.user_led;

endmodule

`default_nettype wire

/* tests/sonata_reg_patterns.txt */
// rows: key, textin, cipherin (byte n in bits 8n+7..8n)
// last row: identify, type, revision in bits 23..0
0f1e2d3c4b5a69788796a5b4c3d2e1f0
00112233445566778899aabbccddeeff
a5a55a5a0123456789abcdeffedcba98
000000000000000000000000002e0204

/* tests/sonata_reg_properties.sv */
`default_nettype none

module sonata_reg_properties import sonata_pkg::*; (
   input wire             usb_clk,
   input wire             reset_i,
   input wire reg_bus_t   reg_bus_i,
   input wire [DATA_W-1:0] read_data_o,
   input wire crypt_cmd_t crypt_cmd_o
);

   // start is a single cycle pulse in both modes
   start_single: assert property (@(posedge usb_clk) disable iff (reset_i)
      crypt_cmd_o.start |=> !crypt_cmd_o.start)
      else $error("start high on two consecutive cycles");

   start_in_reset: assert property (@(posedge usb_clk)
      (reset_i && $past(reset_i)) |-> !crypt_cmd_o.start)
      else $error("start high during reset");

   // read data stage returns zero after idle cycles
   read_zero: assert property (@(posedge usb_clk) disable iff (reset_i)
      !(reg_bus_i.addrvalid && reg_bus_i.read) |=> (read_data_o == '0))
      else $error("read data not zero after a cycle without read");

endmodule

bind sonata_reg_top sonata_reg_properties u_props (
   .usb_clk     (usb_clk),
   .reset_i     (reset_i),
   .reg_bus_i   (reg_bus_i),
   .read_data_o (read_data_o),
   .crypt_cmd_o (crypt_cmd_o)
);

`default_nettype wire

/* tests/tb_sonata_reg.sv */
`default_nettype none

module tb_sonata_reg import sonata_pkg::*; ();

   localparam int NUM_TESTS = 6;

   logic usb_clk, reset_i, mmcm_locked, mmcm_hr_locked, user_led, prev_start;
   logic [DIPS_W-1:0]   dips;
   logic [ANALOG_W-1:0] analog;
   logic [DATA_W-1:0]   rd, read_data;
   logic [BLOCK_W-1:0]  pats [0:3];      // key, textin, cipherin, constants
   logic [BLOCK_W-1:0]  seen_key, seen_text, seen_cipher;
   reg_bus_t   bus;
   crypt_rsp_t rsp;
   crypt_cmd_t cmd;
   integer seed = 32'hb201_20fb;
   int errors = 0, tests_run = 0, start_cnt = 0, adjacent = 0, cnt0;

   sonata_reg_top dut_i (
      .usb_clk (usb_clk), .reset_i (reset_i), .reg_bus_i (bus), .crypt_rsp_i (rsp),
      .mmcm_locked_i (mmcm_locked), .mmcm_hr_locked_i (mmcm_hr_locked),
      .dips_i (dips), .analog_digital_i (analog), .read_data_o (read_data),
      .crypt_cmd_o (cmd), .user_led_o (user_led)
   );

   initial begin
      usb_clk = 1'b0;
      forever #5 usb_clk = ~usb_clk;
   end

   task automatic next_cycle();
      @(posedge usb_clk);
      #1;
   endtask

   task automatic write_byte(input logic [ADDR_W-1:0] a, input int n, input logic [7:0] d);
      bus = '{address: a, bytecnt: BYTECNT_W'(n), write_data: d, read: 1'b0, write: 1'b1,
              addrvalid: 1'b1};
      next_cycle();
      bus = '0;
   endtask

   // data is taken one cycle after the strobe
   task automatic read_byte(input logic [ADDR_W-1:0] a, input int n, output logic [7:0] d);
      bus = '{address: a, bytecnt: BYTECNT_W'(n), write_data: 8'h00, read: 1'b1,
              write: 1'b0, addrvalid: 1'b1};
      next_cycle();
      bus = '0;
      d = read_data;
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %0d (%s) finished, %0d errors so far", tests_run, name, errors);
   endtask

   task automatic check_block(input string what, input logic [ADDR_W-1:0] a,
                              input logic [BLOCK_W-1:0] exp);
      logic [7:0] d;
      for (int i = 0; i < 16; i++) begin
         read_byte(a, i, d);
         check_byte(what, d, exp[8*i +: 8]);
      end
   endtask

   // crypto core model, second done cycle carries junk to catch a double capture
   initial begin
      rsp = '0;
      forever begin
         next_cycle();
         if (!reset_i && cmd.start) begin
            seen_key    = cmd.key;
            seen_text   = cmd.textin;
            seen_cipher = cmd.cipherin;
            next_cycle();
            rsp.busy = 1'b1;
            repeat (5) next_cycle();
            rsp = '{textout: seen_text, cipherout: seen_text ^ seen_key, done: 1'b1,
                    busy: 1'b0};
            next_cycle();
            rsp.textout   = ~seen_text;
            rsp.cipherout = ~seen_text;
            next_cycle();
            rsp = '0;
         end
      end
   end

   always @(posedge usb_clk) begin   // start counter and adjacency monitor
      if (!reset_i && cmd.start) begin
         start_cnt <= start_cnt + 1;
         if (prev_start) adjacent <= adjacent + 1;
      end
      prev_start <= !reset_i && cmd.start;
   end

   initial begin
      #(NUM_TESTS * 200 * 10);
      $display("watchdog: the run timed out before all tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      bus = '0;
      reset_i = 1'b1;
      mmcm_locked = 1'b1;
      mmcm_hr_locked = 1'b0;
      dips = 16'($random(seed));
      analog = 6'h2b;
      $readmemh("tests/sonata_reg_patterns.txt", pats);
      repeat (16) @(posedge usb_clk);
      #1;
      reset_i = 1'b0;
      next_cycle();

      read_byte(REG_IDENTIFY, 0, rd);
      check_byte("identify", rd, pats[3][23:16]);
      read_byte(REG_CRYPT_TYPE, 0, rd);
      check_byte("type", rd, pats[3][15:8]);
      read_byte(REG_CRYPT_REV, 0, rd);
      check_byte("revision", rd, pats[3][7:0]);
      end_test("identification");

      for (int i = 0; i < 16; i++) begin
         write_byte(REG_CRYPT_KEY, i, pats[0][8*i +: 8]);
         write_byte(REG_CRYPT_TEXTIN, i, pats[1][8*i +: 8]);
         write_byte(REG_CRYPT_CIPHERIN, i, pats[2][8*i +: 8]);
      end
      check_block("key", REG_CRYPT_KEY, pats[0]);
      check_block("textin", REG_CRYPT_TEXTIN, pats[1]);
      check_block("cipherin", REG_CRYPT_CIPHERIN, pats[2]);
      write_byte(REG_USER_LED, 0, 8'h01);
      read_byte(REG_USER_LED, 0, rd);
      check_byte("user led", rd, 8'h01);
      check_byte("user_led_o", {7'b0, user_led}, 8'h01);
      end_test("register write and read back");

      cnt0 = start_cnt;
      write_byte(REG_CRYPT_GO, 0, 8'h01);
      repeat (3) next_cycle();
      read_byte(REG_CRYPT_GO, 0, rd);
      check_byte("busy while running", rd, 8'h01);
      wait (rsp.done);
      wait (!rsp.done);
      repeat (3) next_cycle();
      read_byte(REG_CRYPT_GO, 0, rd);
      check_byte("busy after done", rd, 8'h00);
      if (start_cnt - cnt0 != 1) begin
         $display("Fail at %0t: %0d start cycles for one go", $time, start_cnt - cnt0);
         errors++;
      end
      if (seen_key !== pats[0] || seen_text !== pats[1] || seen_cipher !== pats[2]) begin
         $display("Fail at %0t: key, textin or cipherin seen by the core differ", $time);
         errors++;
      end
      end_test("go and busy");

      check_block("textout", REG_CRYPT_TEXTOUT, pats[1]);
      check_block("cipherout", REG_CRYPT_CIPHEROUT, pats[1] ^ pats[0]);
      end_test("result capture");

      cnt0 = start_cnt;
      write_byte(REG_AES_ALWAYS_ON, 0, 8'h01);
      read_byte(REG_AES_ALWAYS_ON, 0, rd);
      check_byte("always-on", rd, 8'h01);
      repeat (60) next_cycle();
      write_byte(REG_AES_ALWAYS_ON, 0, 8'h00);
      if (start_cnt - cnt0 < 3 || adjacent != 0) begin
         $display("Fail at %0t: always-on gave %0d starts, %0d adjacent", $time,
                  start_cnt - cnt0, adjacent);
         errors++;
      end
      repeat (20) next_cycle();
      end_test("always-on restart");

      read_byte(REG_CLKSETTINGS, 0, rd);
      check_byte("clock lock", rd, 8'h01);
      read_byte(REG_DIPS, 0, rd);
      check_byte("dips low", rd, dips[7:0]);
      read_byte(REG_DIPS, 1, rd);
      check_byte("dips high", rd, dips[15:8]);
      read_byte(REG_ANALOG_DIGITAL, 0, rd);
      check_byte("analog digital", rd, {2'b00, analog});
      read_byte(8'h7f, 0, rd);
      check_byte("unknown address", rd, 8'h00);
      end_test("status inputs");

      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
